/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS = $(shell grep -v '^+' $(FILELIST)) bench/bp_model.svh
BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* bench/bp_model.svh */
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

localparam int m_entries = 1 << IDX_W;

br_kind_e   m_kind [m_entries];
logic [1:0] m_ctr  [m_entries];
addr_t      m_btb  [m_entries];
addr_t      m_ras  [$];  // newest at the back
hist_t      m_hist;

// low index slice of the pc folded onto the next slice
function automatic idx_t model_hash(input addr_t a);
    return a[IDX_W-1:0] ^ a[2*IDX_W-1:IDX_W];
endfunction

function automatic void model_reset();
    for (int i = 0; i < m_entries; i++) begin
        m_kind[i] = kind_none;
        m_ctr[i]  = 2'd1;
        m_btb[i]  = '0;
    end
    m_ras.delete();
    m_hist = '0;
endfunction

function automatic void model_update(input resolve_t r);
    idx_t hi;
    idx_t gi;
    hi = model_hash(r.pc);
    gi = hi ^ m_hist;  // history before the shift
    m_kind[hi] = r.kind;
    if (r.kind == kind_cond) begin
        if (r.taken && m_ctr[gi] != 2'd3) begin
            m_ctr[gi] = m_ctr[gi] + 2'd1;
        end else if (!r.taken && m_ctr[gi] != 2'd0) begin
            m_ctr[gi] = m_ctr[gi] - 2'd1;
        end
        m_hist = {m_hist[HIST_W-2:0], r.taken};
    end
    if ((r.kind inside {kind_jump, kind_call, kind_indirect}) ||
        (r.kind == kind_cond && r.taken)) begin
        m_btb[hi] = r.target;
    end
    if (r.kind == kind_call) begin
        if (m_ras.size() == RAS_DEPTH) begin
            void'(m_ras.pop_front());  // oldest falls off
        end
        m_ras.push_back(r.ret_pc);
    end else if (r.kind == kind_ret && m_ras.size() != 0) begin
        void'(m_ras.pop_back());
    end
endfunction

function automatic predict_t model_predict(input addr_t a);
    predict_t p;
    idx_t     hi;
    hi      = model_hash(a);
    p.pc    = a;
    p.kind  = m_kind[hi];
    p.npc   = a + 1'b1;
    p.taken = (p.kind != kind_none);
    if (p.kind == kind_cond) begin
        p.taken = m_ctr[hi ^ m_hist][1];
    end
    if (p.kind == kind_ret) begin
        if (m_ras.size() != 0) begin
            p.npc = m_ras[$];
        end
    end else if (p.taken) begin
        p.npc = m_btb[hi];
    end
    return p;
endfunction

`endif

/* bench/tb_branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;

    import bp_pkg::*;

    localparam int n_untrained = 16;
    localparam int rounds      = 4;
    localparam int n_train     = 64;
    localparam int n_pred      = 40;
    localparam int n_after_rst = 24;
    // stalls can double the lookup time, then reset and gaps on top
    localparam int watchdog_cycles = 16 + rounds * n_train
                                   + 2 * (n_untrained + rounds * n_pred + n_after_rst + 6)
                                   + 50 * (rounds + 3);

    logic     clk = 1'b0;
    logic     rstn;
    logic     stall;
    logic     pc_valid;
    addr_t    pc;
    logic     upd_valid;
    resolve_t upd;
    logic     pred_valid;
    predict_t pred;

    logic [15:0] lfsr;
    addr_t       pc_pool [24];  // last 8 alias onto the first 8
    predict_t    exp_q   [$];
    int          issue_q [$];
    predict_t    got_exp;
    int          got_issue;
    predict_t    last_pred;
    logic        last_valid = 1'b0;
    logic        held = 1'b0;
    bit          check_latency = 1'b0;
    int          cyc = 0;
    int          checked = 0;
    int          mon_errors = 0;
    int          run_errors = 0;

    `include "bp_model.svh"

    branch_predictor #(.ras_depth(RAS_DEPTH)) u_branch_predictor (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .pc_valid   (pc_valid),
        .pc         (pc),
        .upd_valid  (upd_valid),
        .upd        (upd),
        .pred_valid (pred_valid),
        .pred       (pred)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic lfsr_next_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // x^16+x^14+x^13+x^11+1
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_next_bit()};
        end
        return v;
    endfunction

    function automatic addr_t next_lookup_pc(input bit from_pool);
        logic [4:0] k;
        if (!from_pool) begin
            return addr_t'(rand_bits(ADDR_W));
        end
        k = 5'(rand_bits(5) % 24);
        return pc_pool[k];
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            stall     = 1'b0;
            pc_valid  = 1'b0;
            upd_valid = 1'b0;
        end
    endtask

    task automatic issue_lookups(input int n, input bit from_pool, input bit with_stall);
        int    sent;
        addr_t a;
        sent = 0;
        a    = next_lookup_pc(from_pool);
        while (sent < n) begin
            @(posedge clk);
            #2;
            upd_valid = 1'b0;
            stall     = with_stall && rand_bits(2) == 0;
            pc_valid  = 1'b1;
            pc        = a;
            if (!stall) begin  // taken by stage 1 at the coming edge
                exp_q.push_back(model_predict(a));
                issue_q.push_back(cyc);
                sent++;
                a = next_lookup_pc(from_pool);
            end
        end
    endtask

    // round 1 leans to calls, round 2 to returns
    task automatic train_round(input int round);
        resolve_t   r;
        logic [2:0] v;
        for (int i = 0; i < n_train; i++) begin
            v    = 3'(rand_bits(3));
            r.pc = next_lookup_pc(1'b1);
            if (round == 1 && v < 3'd5) begin
                r.kind = kind_call;
            end else if (round == 2 && v < 3'd5) begin
                r.kind = kind_ret;
            end else begin
                r.kind = br_kind_e'(3'(rand_bits(3)) % 3'd6);
            end
            r.taken  = 1'(rand_bits(1));
            r.target = addr_t'(rand_bits(ADDR_W));
            r.ret_pc = addr_t'(rand_bits(ADDR_W));
            @(posedge clk);
            #2;
            upd_valid = 1'b1;
            upd       = r;
            model_update(r);
        end
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            run_errors++;
            $display("pred_valid never came for %0d lookups at %0t", exp_q.size(), $time);
            exp_q.delete();
            issue_q.delete();
        end
    endtask

    task automatic reset_midway();
        issue_lookups(6, 1'b1, 1'b0);
        @(posedge clk);
        #2;
        rstn     = 1'b0;
        pc_valid = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (pred_valid) begin
            run_errors++;
            $display("pred_valid stayed high during reset at %0t", $time);
        end
        exp_q.delete();  // lookups in flight are dropped
        issue_q.delete();
        model_reset();
        @(posedge clk);
        #2;
        rstn = 1'b1;
    endtask

    always @(negedge clk) begin
        if (!rstn) begin
            held = 1'b0;
        end else begin
            if (held && (pred_valid !== last_valid || pred !== last_pred)) begin
                mon_errors++;
                $display("Mismatch at %0t: pred changed while stalled", $time);
            end
            if (pred_valid && !stall) begin
                if (exp_q.size() == 0) begin
                    mon_errors++;
                    $display("prediction for pc %h came with no lookup outstanding", pred.pc);
                end else begin
                    got_exp   = exp_q.pop_front();
                    got_issue = issue_q.pop_front();
                    checked++;
                    if (pred !== got_exp) begin
                        mon_errors++;
                        $display("Mismatch at %0t: pc %h kind %0d/%0d taken %b/%b npc %h/%h",
                                 $time, got_exp.pc, pred.kind, got_exp.kind,
                                 pred.taken, got_exp.taken, pred.npc, got_exp.npc);
                    end
                    if (check_latency && cyc - got_issue != 3) begin
                        mon_errors++;
                        $display("Mismatch at %0t: pc %h latency %0d cycles", $time,
                                 pred.pc, cyc - got_issue);
                    end
                end
            end
            held       = stall;
            last_valid = pred_valid;
            last_pred  = pred;
        end
    end

    initial begin
        #(watchdog_cycles * 40);
        $display("watchdog expired after %0d cycles, run did not complete", watchdog_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        lfsr      = 16'd27692;
        rstn      = 1'b0;
        stall     = 1'b0;
        pc_valid  = 1'b0;
        pc        = '0;
        upd_valid = 1'b0;
        upd       = '0;
        for (int i = 0; i < 24; i++) begin
            if (i < 16) begin
                pc_pool[i] = addr_t'(rand_bits(ADDR_W));
            end else begin  // same index hash, different pc
                pc_pool[i] = pc_pool[i-16] ^ addr_t'({2{idx_t'(rand_bits(IDX_W) | 1)}});
            end
        end
        model_reset();
        repeat (16) @(posedge clk);
        #2;
        rstn = 1'b1;

        check_latency = 1'b1;
        issue_lookups(n_untrained, 1'b0, 1'b0);
        idle_cycles(1);
        wait_drain(20);
        check_latency = 1'b0;

        for (int r = 0; r < rounds; r++) begin
            train_round(r);
            idle_cycles(4);
            issue_lookups(n_pred, 1'b1, 1'b1);
            idle_cycles(1);
            wait_drain(20);
        end

        reset_midway();
        check_latency = 1'b1;
        issue_lookups(n_after_rst, 1'b1, 1'b0);
        idle_cycles(1);
        wait_drain(20);

        $display("checked %0d predictions, %0d check errors, %0d other errors",
                 checked, mon_errors, run_errors);
        if (mon_errors + run_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    // defaults, the module parameters have to agree with these
    localparam int ADDR_W    = 30;
    localparam int IDX_W     = 6;
    localparam int HIST_W    = 6;
    localparam int RAS_DEPTH = 8;

    typedef logic [ADDR_W-1:0] addr_t;  // word pc or target
    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [HIST_W-1:0] hist_t;

    typedef enum logic [2:0] {
        kind_none,
        kind_cond,
        kind_jump,
        kind_call,
        kind_ret,
        kind_indirect
    } br_kind_e;

    // one instruction resolved in execute
    typedef struct packed {
        addr_t    pc;
        br_kind_e kind;
        logic     taken;
        addr_t    target;
        addr_t    ret_pc;
    } resolve_t;

    typedef struct packed {
        addr_t pc;
        idx_t  pc_idx;  // pc only
        idx_t  gh_idx;  // pc hash xor history
    } lookup_t;

    typedef struct packed {
        logic     valid;
        idx_t     pc_idx;
        idx_t     gh_idx;
        resolve_t res;
    } update_t;

    typedef struct packed {
        addr_t    pc;
        br_kind_e kind;
        logic     taken;
        addr_t    npc;  // only meaningful at the output
    } predict_t;

    // low slice folded onto the next slice
    function automatic idx_t pc_hash(input addr_t a);
        return a[IDX_W-1:0] ^ a[2*IDX_W-1:IDX_W];
    endfunction

endpackage

`default_nettype wire

/* source/branch_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
    parameter int addr_w    = bp_pkg::ADDR_W,
    parameter int idx_w     = bp_pkg::IDX_W,
    parameter int hist_w    = bp_pkg::HIST_W,
    parameter int ras_depth = bp_pkg::RAS_DEPTH
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             stall,
    input  logic             pc_valid,
    input  bp_pkg::addr_t    pc,
    input  logic             upd_valid,
    input  bp_pkg::resolve_t upd,
    output logic             pred_valid,
    output bp_pkg::predict_t pred
);

    import bp_pkg::*;

    logic     lk_valid;
    lookup_t  lk;
    update_t  up;   // shared by stages 2 and 3
    logic     dir_valid;
    predict_t dir;

    pc_hash_stage #(
        .hist_w    (hist_w)
    ) u_pc_hash_stage (
        .clk       (clk),
        .rstn      (rstn),
        .stall     (stall),
        .pc_valid  (pc_valid),
        .pc        (pc),
        .upd_valid (upd_valid),
        .upd       (upd),
        .lk_valid  (lk_valid),
        .lk        (lk),
        .up        (up)
    );

    direction_stage #(
        .idx_w     (idx_w)
    ) u_direction_stage (
        .clk       (clk),
        .rstn      (rstn),
        .stall     (stall),
        .lk_valid  (lk_valid),
        .lk        (lk),
        .up        (up),
        .dir_valid (dir_valid),
        .dir       (dir)
    );

    target_stage #(
        .addr_w     (addr_w),
        .idx_w      (idx_w),
        .ras_depth  (ras_depth)
    ) u_target_stage (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .dir_valid  (dir_valid),
        .dir        (dir),
        .up         (up),
        .pred_valid (pred_valid),
        .pred       (pred)
    );

endmodule

`default_nettype wire

/* source/direction_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module direction_stage #(
    parameter int idx_w = bp_pkg::IDX_W
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             stall,
    input  logic             lk_valid,
    input  bp_pkg::lookup_t  lk,
    input  bp_pkg::update_t  up,
    output logic             dir_valid,
    output bp_pkg::predict_t dir
);

    import bp_pkg::*;

    localparam int entries = 1 << idx_w;

    br_kind_e   kind_tab [entries];
    logic [1:0] ctr      [entries];  // gshare counters

    br_kind_e   rd_kind;
    logic       rd_taken;
    logic [1:0] ctr_old;
    logic [1:0] ctr_new;

    // read side for the request leaving stage 1
    always_comb begin
        rd_kind = kind_tab[lk.pc_idx];
        case (rd_kind)
            kind_none: rd_taken = 1'b0;
            kind_cond: rd_taken = ctr[lk.gh_idx][1];
            default:   rd_taken = 1'b1;  // unconditional kinds
        endcase
    end

    // saturating step toward the resolved outcome
    always_comb begin
        ctr_old = ctr[up.gh_idx];
        if (up.res.taken) begin
            ctr_new = (ctr_old == 2'd3) ? 2'd3 : ctr_old + 2'd1;
        end else begin
            ctr_new = (ctr_old == 2'd0) ? 2'd0 : ctr_old - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < entries; i++) begin
                kind_tab[i] <= kind_none;
                ctr[i]      <= 2'd1;  // weakly not taken
            end
        end else if (up.valid) begin
            kind_tab[up.pc_idx] <= up.res.kind;
            if (up.res.kind == kind_cond) begin
                ctr[up.gh_idx] <= ctr_new;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dir_valid <= 1'b0;
        end else if (!stall) begin
            dir_valid <= lk_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dir.pc    <= lk.pc;
            dir.kind  <= rd_kind;
            dir.taken <= rd_taken;
            dir.npc   <= '0;  // filled in by stage 3
        end
    end

    // trained counter moves toward the outcome and never wraps past 0 or 3
    a_ctr_step: assert property (
        @(posedge clk) disable iff (!rstn)
        up.valid && up.res.kind == kind_cond |=>
            ($past(up.res.taken) ? ctr[$past(up.gh_idx)] >= $past(ctr_old)
                                 : ctr[$past(up.gh_idx)] <= $past(ctr_old))
    );

endmodule

`default_nettype wire

/* source/pc_hash_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_hash_stage #(
    parameter int hist_w = bp_pkg::HIST_W
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             stall,
    input  logic             pc_valid,
    input  bp_pkg::addr_t    pc,
    input  logic             upd_valid,
    input  bp_pkg::resolve_t upd,
    output logic             lk_valid,
    output bp_pkg::lookup_t  lk,
    output bp_pkg::update_t  up
);

    import bp_pkg::*;

    logic [hist_w-1:0] gh;   // global history, newest outcome in bit 0
    idx_t              fetch_idx;
    idx_t              upd_idx;

    assign fetch_idx = pc_hash(pc);
    assign upd_idx   = pc_hash(upd.pc);

    // update path, seen by stages 2 and 3 in the same cycle
    assign up.valid  = upd_valid;
    assign up.pc_idx = upd_idx;
    assign up.gh_idx = upd_idx ^ idx_t'(gh);  // history before the shift
    assign up.res    = upd;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            gh <= '0;
        end else if (upd_valid && upd.kind == kind_cond) begin
            gh <= hist_w'({gh, upd.taken});
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lk_valid <= 1'b0;
        end else if (!stall) begin
            lk_valid <= pc_valid;
        end
    end

    // lookup payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            lk.pc     <= pc;
            lk.pc_idx <= fetch_idx;
            lk.gh_idx <= fetch_idx ^ idx_t'(gh);
        end
    end

    // an X pc would index every table downstream with X
    a_pc_known: assert property (
        @(posedge clk) disable iff (!rstn)
        pc_valid |-> !$isunknown(pc)
    );

endmodule

`default_nettype wire

/* source/target_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module target_stage #(
    parameter int addr_w    = bp_pkg::ADDR_W,
    parameter int idx_w     = bp_pkg::IDX_W,
    parameter int ras_depth = bp_pkg::RAS_DEPTH
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             stall,
    input  logic             dir_valid,
    input  bp_pkg::predict_t dir,
    input  bp_pkg::update_t  up,
    output logic             pred_valid,
    output bp_pkg::predict_t pred
);

    import bp_pkg::*;

    localparam int entries = 1 << idx_w;
    localparam int ptr_w   = (ras_depth > 1) ? $clog2(ras_depth) : 1;
    localparam int cnt_w   = $clog2(ras_depth + 1);

    logic [addr_w-1:0] btb [entries];
    logic [addr_w-1:0] ras [ras_depth];  // circular, oldest overwritten

    logic [ptr_w-1:0]  top;              // slot of the newest entry
    logic [cnt_w-1:0]  count;
    logic [ptr_w-1:0]  top_inc;
    logic [ptr_w-1:0]  top_dec;
    logic              btb_wr;
    logic              do_push;
    logic              do_pop;
    idx_t              btb_idx;
    logic [addr_w-1:0] seq_pc;
    logic [addr_w-1:0] npc;

    assign top_inc = (top == ptr_w'(ras_depth - 1)) ? '0 : top + 1'b1;
    assign top_dec = (top == '0) ? ptr_w'(ras_depth - 1) : top - 1'b1;

    assign do_push = up.valid && up.res.kind == kind_call;
    assign do_pop  = up.valid && up.res.kind == kind_ret && count != '0;

    assign btb_wr = up.valid &&
                    ((up.res.kind inside {kind_jump, kind_call, kind_indirect}) ||
                     (up.res.kind == kind_cond && up.res.taken));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < entries; i++) begin
                btb[i] <= '0;
            end
        end else if (btb_wr) begin
            btb[up.pc_idx] <= up.res.target;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            top   <= '0;
            count <= '0;
        end else if (do_push) begin
            top <= top_inc;
            if (count != cnt_w'(ras_depth)) begin
                count <= count + 1'b1;
            end
        end else if (do_pop) begin
            top   <= top_dec;
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            ras[top_inc] <= up.res.ret_pc;
        end
    end

    // next pc for the request leaving stage 2
    assign btb_idx = pc_hash(dir.pc);
    assign seq_pc  = dir.pc + 1'b1;

    always_comb begin
        if (dir.kind == kind_ret) begin
            npc = (count != '0) ? ras[top] : seq_pc;  // empty stack falls through
        end else if (dir.taken) begin
            npc = btb[btb_idx];
        end else begin
            npc = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pred_valid <= 1'b0;
        end else if (!stall) begin
            pred_valid <= dir_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pred.pc    <= dir.pc;
            pred.kind  <= dir.kind;
            pred.taken <= dir.taken;
            pred.npc   <= npc;
        end
    end

    a_ras_count: assert property (
        @(posedge clk) disable iff (!rstn)
        count <= cnt_w'(ras_depth)
    );

endmodule

`default_nettype wire

/* tb.f */
+incdir+bench
source/bp_pkg.sv
source/pc_hash_stage.sv
source/direction_stage.sv
source/target_stage.sv
source/branch_predictor.sv
bench/tb_branch_predictor.sv
